// File: Bender.yml
package:
  name: transition_detector

sources:
  - files:
      - common/detectorPkg.sv
      - transitionFilter/tapDelayLine.sv
      - transitionFilter/foldedProducts.sv
      - transitionFilter/productAccumulator.sv
      - logic/transitionDetector.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/detectorTb.sv

// File: common/detectorPkg.sv
//*********************************************************************
// Shared widths, fixed-point types and coefficient table for the
// signal transition detector. RTL blocks import it inside the module
// body and use scoped names in their port lists.
//*********************************************************************

package detectorPkg;

	// filter geometry
	localparam int sampleWidth = 12;              // input and output sample width
	localparam int tapCount    = 31;              // odd length, center tap in the middle
	localparam int delayDepth  = tapCount - 1;    // registered stages behind tap 0
	localparam int foldCount   = (tapCount - 1) / 2; // pairs k and 30-k, center index 15

	// fixed-point formats, scale noted per type
	typedef logic signed [sampleWidth-1:0] sampleType;  // 2^-10 at the input
	typedef logic        [11:0]            coefType;    // unsigned, 2^-12
	typedef logic signed [sampleWidth:0]   foldType;    // exact difference of two samples
	typedef logic signed [15:0]            productType; // truncated product, 2^-16
	typedef logic signed [13:0]            partialType; // running sum, 2^-14

	// Antisymmetric coefficient set. Entries 0..14 weight the folded
	// pairs from the outside in, entry 15 weights the center tap alone.
	// Values are in units of 2^-12.
	localparam coefType coefTable [foldCount+1] = '{
		12'd22,    // taps 0 / 30
		12'd21,    // taps 1 / 29
		12'd19,
		12'd18,
		12'd16,
		12'd15,
		12'd14,
		12'd12,
		12'd11,
		12'd10,
		12'd8,
		12'd7,
		12'd5,
		12'd4,
		12'd3,     // taps 14 / 16
		12'd1      // center tap 15
	};

endpackage

// File: list.f
+incdir+verif
common/detectorPkg.sv
transitionFilter/tapDelayLine.sv
transitionFilter/foldedProducts.sv
transitionFilter/productAccumulator.sv
logic/transitionDetector.sv
verif/detectorTb.sv

// File: logic/transitionDetector.sv
//*********************************************************************
// Top level of the signal transition detector, a 31-tap antisymmetric
// FIR. Takes one signed sample per clock and returns the filtered
// sample one cycle later. No handshake.
//*********************************************************************

module transitionDetector #(
	parameter int sampleWidth = detectorPkg::sampleWidth,
	parameter int delayDepth  = detectorPkg::delayDepth
) (
	input  logic                  clk,
	input  logic                  reset,
	input  detectorPkg::sampleType sampleIn,
	output detectorPkg::sampleType sampleOut
);

	import detectorPkg::*;

	logic signed [sampleWidth-1:0] taps [delayDepth];      // taps 1..30
	productType                    products [foldCount+1]; // 15 folds plus center

	tapDelayLine #(
		.sampleWidth (sampleWidth),
		.delayDepth  (delayDepth)
	) delayLine (
		.clk      (clk),
		.reset    (reset),
		.sampleIn (sampleIn),
		.taps     (taps)
	);

	// live input doubles as tap 0
	foldedProducts folder (
		.sampleIn (sampleIn),
		.taps     (taps),
		.products (products)
	);

	productAccumulator accumulator (
		.clk       (clk),
		.reset     (reset),
		.products  (products),
		.sampleOut (sampleOut)
	);

endmodule

// File: transitionFilter/foldedProducts.sv
//*********************************************************************
// Folded multiply stage of the transition filter. Subtracts each tap
// pair k / 30-k, scales the difference by its fixed coefficient and
// truncates the result to the 16-bit product format. Combinational.
//*********************************************************************

module foldedProducts (
	input  detectorPkg::sampleType  sampleIn,
	input  detectorPkg::sampleType  taps [detectorPkg::delayDepth],
	output detectorPkg::productType products [detectorPkg::foldCount+1]
);

	import detectorPkg::*;

	// full product is the 13-bit coefficient times a 13-bit fold
	localparam int wideWidth  = $bits(coefType) + 1 + $bits(foldType);
	localparam int dropBits   = 6;                                // 2^-22 down to 2^-16
	localparam int productTop = dropBits + $bits(productType) - 1;

	foldType folds [foldCount];

	for (genvar k = 0; k < foldCount; k++) begin : genFold
		sampleType               nearTap;
		sampleType               farTap;
		logic signed [wideWidth-1:0] wideProduct;

		// tap 0 is the live input, tap k>0 sits at delay entry k-1
		if (k == 0) begin : genLive
			assign nearTap = sampleIn;
		end else begin : genDelayed
			assign nearTap = taps[k-1];
		end
		assign farTap = taps[delayDepth-1-k];     // tap 30-k

		// exact, 13 bits cannot overflow
		assign folds[k] = {nearTap[sampleWidth-1], nearTap}
			- {farTap[sampleWidth-1], farTap};

		assign wideProduct = $signed({1'b0, coefTable[k]}) * folds[k];
		assign products[k] = wideProduct[productTop:dropBits]; // upper bits wrap
	end

	// The center tap has no partner, so it is scaled directly. Sign
	// extension to the wide width follows from both operands being signed.
	logic signed [wideWidth-1:0] centerWide;

	assign centerWide = $signed({1'b0, coefTable[foldCount]}) * taps[foldCount-1];
	assign products[foldCount] = centerWide[productTop:dropBits];

endmodule

// File: transitionFilter/productAccumulator.sv
//*********************************************************************
// Adder chain and output register of the transition filter. Adds the
// products in table order, dropping two bits after every step, then
// reduces to the sample width and registers the result.
//*********************************************************************

module productAccumulator (
	input  logic                    clk,
	input  logic                    reset,
	input  detectorPkg::productType products [detectorPkg::foldCount+1],
	output detectorPkg::sampleType  sampleOut
);

	import detectorPkg::*;

	localparam int sumWidth   = $bits(productType);                  // 2^-16 adder grid
	localparam int alignShift = sumWidth - $bits(partialType);       // 2^-14 partials
	localparam int outShift   = sumWidth - $bits(sampleType);        // 2^-12 result
	localparam int chainLen   = foldCount - 1;                       // partials 0..13

	partialType partials [chainLen];
	sampleType  resultNext;

	// first step pairs products 0 and 1 directly
	logic [sumWidth-1:0] firstSum;

	assign firstSum    = products[1] + products[0];
	assign partials[0] = firstSum[sumWidth-1:alignShift];

	// Every later step realigns the previous partial onto the product
	// grid. Only the low sumWidth bits reach the slice, so anything
	// above them is allowed to wrap.
	for (genvar i = 1; i < chainLen; i++) begin : genChain
		logic [sumWidth-1:0] stepSum;

		assign stepSum     = products[i+1] + {partials[i-1], alignShift'(0)};
		assign partials[i] = stepSum[sumWidth-1:alignShift];
	end

	// center product joins last, four bits drop to reach sample width
	logic [sumWidth-1:0] finalSum;

	assign finalSum   = products[foldCount] + {partials[chainLen-1], alignShift'(0)};
	assign resultNext = finalSum[sumWidth-1:outShift];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sampleOut <= '0;
		end else begin
			sampleOut <= resultNext;      // one cycle of latency
		end
	end

endmodule

// File: transitionFilter/tapDelayLine.sv
//*********************************************************************
// Sample delay line of the transition filter. Shifts one stage per
// clock and presents every stored sample as a tap; entry 0 holds the
// sample taken one cycle ago, the last entry the oldest one.
//*********************************************************************

module tapDelayLine #(
	parameter int sampleWidth = 12,
	parameter int delayDepth  = 30
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic signed [sampleWidth-1:0] sampleIn,
	output logic signed [sampleWidth-1:0] taps [delayDepth]
);

	// one register per stage, all shifted together
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < delayDepth; i++) begin
				taps[i] <= '0;            // start from a silent history
			end
		end else begin
			taps[0] <= sampleIn;          // newest sample enters here
			for (int i = 1; i < delayDepth; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

endmodule

// File: verif/detectorModel.svh
//*********************************************************************
// Reference model of the transition filter for the testbench. Keeps
// the last 31 input samples, newest first, and computes the expected
// registered output from the fold, slice and accumulation rules.
//*********************************************************************

`ifndef DETECTOR_MODEL_SVH
`define DETECTOR_MODEL_SVH

int history [tapCount] = '{default: 0};   // history[k] is tap x[k]

task automatic clearHistory();
	for (int i = 0; i < tapCount; i++) begin
		history[i] = 0;
	end
endtask

task automatic pushSample(input int value);
	for (int i = tapCount - 1; i > 0; i--) begin
		history[i] = history[i-1];
	end
	history[0] = value;                    // becomes tap 0
endtask

// keep the low bits of a value and read them back as signed
function automatic int wrapBits(input int value, input int bits);
	int span;
	int low;
	span = 1 << bits;
	low  = value & (span - 1);
	if (low >= (span >> 1)) begin
		low = low - span;
	end
	return low;
endfunction

// bits 21..6 of the full product
function automatic int truncProduct(input int coef, input int operand);
	return wrapBits((coef * operand) >>> 6, 16);
endfunction

function automatic int referenceOutput();
	int products [foldCount+1];
	int fold;
	int sum;
	int partial;
	for (int k = 0; k < foldCount; k++) begin
		fold        = history[k] - history[tapCount-1-k];  // exact difference
		products[k] = truncProduct(int'(coefTable[k]), fold);
	end
	products[foldCount] = truncProduct(int'(coefTable[foldCount]), history[foldCount]);
	sum     = products[1] + products[0];
	partial = wrapBits(sum >>> 2, 14);
	for (int k = 2; k < foldCount; k++) begin
		sum     = products[k] + 4 * partial;
		partial = wrapBits(sum >>> 2, 14);     // drop two bits per step
	end
	sum = products[foldCount] + 4 * partial;
	return wrapBits(sum >>> 4, sampleWidth);
endfunction

`endif

// File: verif/detectorTb.sv
//*********************************************************************
// Testbench of the signal transition detector. Drives reset, quiet,
// impulse, constant, step and random input, and compares every
// registered output with the reference model one cycle later.
//*********************************************************************

module detectorTb;

	timeunit 1ns;
	timeprecision 1ps;

	import detectorPkg::*;

	localparam int clkPeriod    = 100;
	localparam int resetCycles  = 5;
	localparam int quietCycles  = 40;
	localparam int drainCycles  = 40;    // impulse must leave all 31 taps
	localparam int settleCycles = 45;
	localparam int stepHold     = 35;
	localparam int stepCount    = 4;
	localparam int toggleCycles = 40;
	localparam int randomCycles = 400;
	localparam int tailCycles   = 35;
	localparam int totalCycles  = resetCycles + quietCycles + 2 * (1 + drainCycles)
		+ 2 * (settleCycles + 1) + stepCount * stepHold + toggleCycles
		+ randomCycles + tailCycles + 3;

	logic      clk = 1'b0;
	logic      reset;
	sampleType sampleIn;
	sampleType sampleOut;
	sampleType expectedOut = '0;
	int        errorCount  = 0;
	int        checkCount  = 0;

	transitionDetector DUT (
		.clk       (clk),
		.reset     (reset),
		.sampleIn  (sampleIn),
		.sampleOut (sampleOut)
	);

	`include "detectorModel.svh"

	always #(clkPeriod / 2) clk = ~clk;

	task automatic reportMismatch(input string name, input int expected, input int actual);
		$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
		errorCount++;
	endtask

	task automatic driveSample(input sampleType value);
		@(posedge clk);
		#5 sampleIn = value;
	endtask

	task automatic holdSample(input sampleType value, input int cycles);
		repeat (cycles) driveSample(value);
	endtask

	// with every tap equal only the center product survives
	task automatic checkSettled(input sampleType value);
		int centerOnly;
		centerOnly = ((int'(value) >>> 6) >>> 4);
		@(posedge clk);
		#10;
		if (sampleOut !== sampleType'(centerOnly)) begin
			reportMismatch("sampleOut", centerOnly, sampleOut);
		end
	endtask

	// model follows the DUT edge by edge
	always @(posedge clk or posedge reset) begin
		if (reset) begin
			clearHistory();
			expectedOut = '0;
		end else begin
			pushSample(sampleIn);          // value present before this edge
			expectedOut = sampleType'(referenceOutput());
		end
	end

	always @(posedge clk) begin
		#10;
		checkCount++;
		if (sampleOut !== expectedOut) begin
			reportMismatch("sampleOut", expectedOut, sampleOut);
		end
	end

	initial begin
		#(totalCycles * clkPeriod + 50 * clkPeriod);
		$display("Watchdog expired before the stimulus finished, run stopped");
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(97));
		reset    = 1'b1;
		sampleIn = '0;
		repeat (resetCycles) begin
			@(posedge clk);
			#5;
			if (sampleOut !== '0) begin
				reportMismatch("sampleOut", 0, sampleOut);
			end
		end
		reset = 1'b0;

		holdSample(12'sd0, quietCycles);

		driveSample(12'sd1024);            // 1.0 at the input scale
		holdSample(12'sd0, drainCycles);
		driveSample(-12'sd2048);
		holdSample(12'sd0, drainCycles);

		holdSample(12'sd1000, settleCycles);
		checkSettled(12'sd1000);
		holdSample(-12'sd1500, settleCycles);
		checkSettled(-12'sd1500);

		for (int s = 0; s < stepCount; s++) begin
			holdSample((s % 2 == 0) ? 12'sd2047 : -12'sd2048, stepHold);
		end
		for (int s = 0; s < toggleCycles; s++) begin
			driveSample((s % 2 == 0) ? -12'sd2048 : 12'sd2047);
		end

		for (int s = 0; s < randomCycles; s++) begin
			driveSample(sampleType'($urandom() & 32'hFFF));
		end
		holdSample(12'sd0, tailCycles);

		repeat (2) @(posedge clk);
		#20;
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
